//--- compile.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_channel.sv
src/uart_bus_decode.sv
src/uart_read_mux.sv
src/multi_uart_top.sv
test/tb_multi_uart.sv

//--- test/uart_trace.txt
# op ch reg value(hex): W write, R read and compare, P poll reg until equal
# I compare irq vector against value: reg 0 is irq_tx_o, reg 1 is irq_rx_o
R 0 2 35
R 1 2 35
R 2 2 35
R 3 2 35
R 0 1 2
R 1 1 2
R 2 1 2
R 3 1 2
I 0 0 f
I 0 1 0
W 0 2 3
W 1 2 4
W 2 2 5
W 3 2 6
R 0 2 3
R 1 2 4
R 2 2 5
R 3 2 6
W 0 0 a5
P 0 1 3
R 0 0 a5
R 0 1 2
W 1 0 3c
P 1 1 3
I 0 1 2
I 0 0 f
R 1 0 3c
R 1 1 2
W 2 0 5a
P 2 1 3
R 2 0 5a
R 2 1 2
W 3 0 c3
P 3 1 3
R 3 0 c3
R 3 1 2
W 0 0 11
W 0 0 22
W 0 0 33
P 0 1 3
I 0 1 1
I 0 0 e
R 0 0 11
P 0 1 3
R 0 0 22
P 0 1 3
I 0 0 f
R 0 0 33
R 0 1 2
I 0 1 0
R 2 3 0
R 3 0 0

//--- test/tb_multi_uart.sv
/*
 * Trace-driven testbench for the multi-channel UART.
 * Every serial output is looped back to the same channel's input.
 * Bus operations and expected values come from test/uart_trace.txt;
 * a cycle counter ends a run that stops making progress.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_multi_uart import uart_pkg::*; ();

    localparam int    NUM_CH         = 4;
    localparam int    FIFO_PTR_WIDTH = 3;
    localparam int    CH_WIDTH       = $clog2(NUM_CH);
    localparam string TRACE_FILE     = "test/uart_trace.txt";

    logic                clk;
    logic                reset;
    logic [CH_WIDTH+1:0] wb_adr_i;
    bus_data_t           wb_dat_i;
    logic                wb_we_i;
    logic                wb_stb_i;
    bus_data_t           wb_dat_o;
    logic                wb_ack_o;
    logic [NUM_CH-1:0]   uart_line;
    logic [NUM_CH-1:0]   irq_tx;
    logic [NUM_CH-1:0]   irq_rx;

    // parsed trace, one entry per operation
    byte       op_q [$];
    int        ch_q [$];
    int        reg_q [$];
    bus_data_t val_q [$];

    int unsigned cycle_limit = 0;
    int unsigned cycle_cnt = 0;

    multi_uart_top #(
        .NUM_CH         (NUM_CH),
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_we_i   (wb_we_i),
        .wb_stb_i  (wb_stb_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .uart_tx_o (uart_line),
        .uart_rx_i (uart_line),
        .irq_tx_o  (irq_tx),
        .irq_rx_o  (irq_rx)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // --------------------------------------------------
    // run length guard
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!reset && cycle_limit != 0) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= cycle_limit) begin
                $display("timeout: trace not finished after %0d cycles", cycle_limit);
                $display("** FAIL **");
                $fatal(1, "simulation stopped by timeout");
            end
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_bus_data(input string name, input bus_data_t got,
                                  input bus_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %0t ns %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_irq(input string name, input logic [NUM_CH-1:0] got,
                             input logic [NUM_CH-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %0t ns %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // trace reader, also sizes the timeout
    // --------------------------------------------------
    task automatic load_trace();
        int        fd;
        int        n;
        string     line;
        byte       op;
        int        ch;
        int        rg;
        bus_data_t val;
        divider_t  max_div;
        max_div = DIVIDER_INIT;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            stop_on_error({"cannot open trace file ", TRACE_FILE});
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            n = $sscanf(line, "%c %d %d %h", op, ch, rg, val);
            if (n != 4) begin
                stop_on_error({"trace line could not be parsed: ", line});
            end
            if (op == "W" && rg == REG_DIVIDER && val[7:0] > max_div) begin
                max_div = val[7:0];
            end
            op_q.push_back(op);
            ch_q.push_back(ch);
            reg_q.push_back(rg);
            val_q.push_back(val);
        end
        $fclose(fd);
        cycle_limit = op_q.size() * 12 * (max_div + 1) + 1000;
    endtask

    // one strobed cycle, read data sampled mid-cycle
    task automatic access_bus(input int ch, input int rg, input logic we,
                              input bus_data_t wdata, output bus_data_t rdata);
        @(posedge clk);
        wb_adr_i <= {CH_WIDTH'(ch), 2'(rg)};
        wb_dat_i <= wdata;
        wb_we_i  <= we;
        wb_stb_i <= 1'b1;
        @(negedge clk);
        rdata = wb_dat_o;
        if (wb_ack_o !== 1'b1) begin
            stop_on_error("bus access was not acknowledged in its own cycle");
        end
    endtask

    // bus at rest reads zero with no acknowledge
    task automatic go_idle();
        @(posedge clk);
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge clk);
        check_bus_data("wb_dat_o idle", wb_dat_o, '0);
        if (wb_ack_o !== 1'b0) begin
            stop_on_error("bus acknowledged a cycle without a strobe");
        end
    endtask

    task automatic poll_until(input int ch, input int rg, input bus_data_t target);
        bus_data_t rdata;
        access_bus(ch, rg, 1'b0, '0, rdata);
        while (rdata !== target) begin
            access_bus(ch, rg, 1'b0, '0, rdata);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        bus_data_t rdata;
        string     name;
        reset    = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_we_i  = 1'b0;
        wb_stb_i = 1'b0;
        load_trace();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // serial lines idle high out of reset
        check_irq("uart_tx_o", uart_line, '1);
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": access_bus(ch_q[i], reg_q[i], 1'b1, val_q[i], rdata);
                "R": begin
                    access_bus(ch_q[i], reg_q[i], 1'b0, '0, rdata);
                    name = $sformatf("wb_dat_o ch%0d reg%0d", ch_q[i], reg_q[i]);
                    check_bus_data(name, rdata, val_q[i]);
                end
                "P": poll_until(ch_q[i], reg_q[i], val_q[i]);
                "I": begin
                    go_idle();
                    if (reg_q[i] == 0) begin
                        check_irq("irq_tx_o", irq_tx, val_q[i][NUM_CH-1:0]);
                    end else begin
                        check_irq("irq_rx_o", irq_rx, val_q[i][NUM_CH-1:0]);
                    end
                end
                default: stop_on_error($sformatf("unknown trace operation at entry %0d", i));
            endcase
        end
        go_idle();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/multi_uart_top.sv
/*
 * Multi-channel UART on a single-cycle register bus.
 * NUM_CH channels, each with data, status and divider registers.
 * Address bits above the low two select the channel; every
 * strobe is acknowledged in the same cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module multi_uart_top import uart_pkg::*; #(
    parameter  int NUM_CH         = 4,
    parameter  int FIFO_PTR_WIDTH = 3,
    localparam int CH_WIDTH       = $clog2(NUM_CH)
) (
    input  var logic                clk,
    input  var logic                reset,

    // register bus
    input  var logic [CH_WIDTH+1:0] wb_adr_i,
    input  var bus_data_t           wb_dat_i,
    input  var logic                wb_we_i,
    input  var logic                wb_stb_i,
    output var bus_data_t           wb_dat_o,
    output var logic                wb_ack_o,

    // serial lines and interrupts
    output var logic [NUM_CH-1:0]   uart_tx_o,
    input  var logic [NUM_CH-1:0]   uart_rx_i,
    output var logic [NUM_CH-1:0]   irq_tx_o,
    output var logic [NUM_CH-1:0]   irq_rx_o
);

    chan_ctrl_t          ctrl [NUM_CH];
    chan_stat_t          stat [NUM_CH];
    logic [CH_WIDTH-1:0] ch_sel;
    reg_adr_t            reg_sel;

    uart_bus_decode #(
        .NUM_CH (NUM_CH)
    ) u_decode (
        .adr_i     (wb_adr_i),
        .dat_i     (wb_dat_i),
        .we_i      (wb_we_i),
        .stb_i     (wb_stb_i),
        .ctrl_o    (ctrl),
        .ch_sel_o  (ch_sel),
        .reg_sel_o (reg_sel)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        uart_channel #(
            .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
        ) u_channel (
            .clk    (clk),
            .reset  (reset),
            .ctrl_i (ctrl[i]),
            .stat_o (stat[i]),
            .tx_o   (uart_tx_o[i]),
            .rx_i   (uart_rx_i[i])
        );
    end

    uart_read_mux #(
        .NUM_CH (NUM_CH)
    ) u_read_mux (
        .stb_i     (wb_stb_i),
        .ch_sel_i  (ch_sel),
        .reg_sel_i (reg_sel),
        .stat_i    (stat),
        .dat_o     (wb_dat_o),
        .ack_o     (wb_ack_o),
        .irq_tx_o  (irq_tx_o),
        .irq_rx_o  (irq_rx_o)
    );

endmodule

`default_nettype wire

//--- src/uart_read_mux.sv
/*
 * Bus read side.
 * Picks the addressed channel's status and forms the read word
 * in the same cycle as the strobe, acknowledges every strobe
 * and gathers the per-channel interrupt lines.
 */

`timescale 1ns/1ns
`default_nettype none

module uart_read_mux import uart_pkg::*; #(
    parameter  int NUM_CH   = 4,
    localparam int CH_WIDTH = $clog2(NUM_CH)
) (
    input  var logic                stb_i,
    input  var logic [CH_WIDTH-1:0] ch_sel_i,
    input  var reg_adr_t            reg_sel_i,
    input  var chan_stat_t          stat_i [NUM_CH],
    output var bus_data_t           dat_o,
    output var logic                ack_o,
    output var logic [NUM_CH-1:0]   irq_tx_o,
    output var logic [NUM_CH-1:0]   irq_rx_o
);

    chan_stat_t sel;

    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (ch_sel_i == CH_WIDTH'(i)) begin
                sel = stat_i[i];
            end
        end
    end

    always_comb begin
        dat_o = '0;
        if (stb_i) begin
            case (reg_sel_i)
                REG_DATA:    dat_o = bus_data_t'(sel.rx_data);
                REG_STATUS:  dat_o = bus_data_t'({sel.tx_ready, sel.rx_valid});
                REG_DIVIDER: dat_o = bus_data_t'(sel.divider);
                default:     dat_o = '0;
            endcase
        end
    end

    assign ack_o = stb_i;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            irq_tx_o[i] = stat_i[i].tx_idle;
            irq_rx_o[i] = stat_i[i].rx_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_bus_decode.sv
/*
 * Bus address decoder.
 * Splits the address into channel and register and turns a
 * strobed access into push, pop or divider-load pulses for the
 * addressed channel only. The selects also go to the read mux.
 */

`timescale 1ns/1ns
`default_nettype none

module uart_bus_decode import uart_pkg::*; #(
    parameter  int NUM_CH   = 4,
    localparam int CH_WIDTH = $clog2(NUM_CH)
) (
    input  var logic [CH_WIDTH+1:0] adr_i,
    input  var bus_data_t           dat_i,
    input  var logic                we_i,
    input  var logic                stb_i,
    output var chan_ctrl_t          ctrl_o [NUM_CH],
    output var logic [CH_WIDTH-1:0] ch_sel_o,
    output var reg_adr_t            reg_sel_o
);

    logic data_wr;
    logic data_rd;
    logic div_wr;

    // upper bits pick the channel, low two the register
    assign ch_sel_o  = adr_i[CH_WIDTH+1:2];
    assign reg_sel_o = reg_adr_t'(adr_i[1:0]);

    assign data_wr = stb_i && we_i && (reg_sel_o == REG_DATA);
    assign data_rd = stb_i && !we_i && (reg_sel_o == REG_DATA);
    assign div_wr  = stb_i && we_i && (reg_sel_o == REG_DIVIDER);

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            ctrl_o[i]       = CHAN_CTRL_NONE;
            ctrl_o[i].wdata = dat_i[7:0];
            if (ch_sel_o == CH_WIDTH'(i)) begin
                ctrl_o[i].tx_push = data_wr;
                ctrl_o[i].rx_pop  = data_rd;
                ctrl_o[i].div_wr  = div_wr;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/uart_channel.sv
/*
 * One complete UART channel.
 * Owns the baud divider register, a TX and an RX FIFO, the
 * transmitter and the receiver. Driven by a control struct from
 * the bus decoder and reports its state in a status struct.
 */

`timescale 1ns/1ns
`default_nettype none

module uart_channel import uart_pkg::*; #(
    parameter int FIFO_PTR_WIDTH = 3
) (
    input  var logic       clk,
    input  var logic       reset,
    input  var chan_ctrl_t ctrl_i,
    output var chan_stat_t stat_o,
    output var logic       tx_o,
    input  var logic       rx_i
);

    divider_t divider;

    byte_t tx_head;
    logic  tx_empty;
    logic  tx_full;
    logic  tx_start;
    logic  tx_busy;

    byte_t rx_byte;
    logic  rx_done;
    byte_t rx_head;
    logic  rx_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            divider <= DIVIDER_INIT;
        end else if (ctrl_i.div_wr) begin
            divider <= divider_t'(ctrl_i.wdata);
        end
    end

    // --------------------------------------------------
    // transmit path
    // --------------------------------------------------
    uart_fifo #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) u_tx_fifo (
        .clk     (clk),
        .reset   (reset),
        .push_i  (ctrl_i.tx_push),
        .wdata_i (ctrl_i.wdata),
        .pop_i   (tx_start),
        .rdata_o (tx_head),
        .empty_o (tx_empty),
        .full_o  (tx_full)
    );

    uart_tx u_tx (
        .clk       (clk),
        .reset     (reset),
        .divider_i (divider),
        .data_i    (tx_head),
        .valid_i   (!tx_empty),
        .start_o   (tx_start),
        .busy_o    (tx_busy),
        .tx_o      (tx_o)
    );

    // --------------------------------------------------
    // receive path
    // --------------------------------------------------
    uart_rx u_rx (
        .clk       (clk),
        .reset     (reset),
        .divider_i (divider),
        .rx_i      (rx_i),
        .data_o    (rx_byte),
        .done_o    (rx_done)
    );

    // overflow drops the new byte
    uart_fifo #(
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) u_rx_fifo (
        .clk     (clk),
        .reset   (reset),
        .push_i  (rx_done),
        .wdata_i (rx_byte),
        .pop_i   (ctrl_i.rx_pop),
        .rdata_o (rx_head),
        .empty_o (rx_empty),
        .full_o  ()
    );

    assign stat_o.rx_data  = rx_empty ? byte_t'(0) : rx_head;
    assign stat_o.rx_valid = !rx_empty;
    assign stat_o.tx_ready = !tx_full;
    assign stat_o.tx_idle  = tx_empty && !tx_busy;
    assign stat_o.divider  = divider;

endmodule

`default_nettype wire

//--- src/uart_rx.sv
/*
 * UART receiver, 8N1, one sample per bit.
 * Finds the falling edge of the start bit, confirms it at half a
 * bit period and then samples every bit in its middle. done_o
 * pulses for one clock with data_o valid when the stop bit is
 * high; frames with a low stop bit are dropped.
 */

`timescale 1ns/1ns
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  var logic     clk,
    input  var logic     reset,
    input  var divider_t divider_i,
    input  var logic     rx_i,
    output var byte_t    data_o,
    output var logic     done_o
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    divider_t   cnt;
    logic [2:0] bit_idx;
    byte_t      shreg;
    divider_t   half;

    assign half   = divider_i >> 1;
    assign data_o = shreg;

    // --------------------------------------------------
    // input synchronizer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // --------------------------------------------------
    // frame FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            cnt    <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    if (cnt == half) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch, not a start bit
                        state   <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (cnt == divider_i) begin
                        cnt   <= '0;
                        shreg <= {rx_sync, shreg[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (cnt == divider_i) begin
                        cnt    <= '0;
                        done_o <= rx_sync;
                        state  <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
/*
 * UART transmitter, 8N1.
 * Takes data_i when idle and valid_i is high, pulsing start_o
 * to pop the source FIFO, then shifts out start bit, eight data
 * bits LSB first and stop bit, each divider_i + 1 clocks long.
 */

`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  var logic     clk,
    input  var logic     reset,
    input  var divider_t divider_i,
    input  var byte_t    data_i,
    input  var logic     valid_i,
    output var logic     start_o,
    output var logic     busy_o,
    output var logic     tx_o
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    tx_state_t  state;
    divider_t   cnt;
    logic [2:0] bit_idx;
    byte_t      shreg;
    logic       bit_end;

    assign start_o = (state == IDLE) && valid_i;
    assign busy_o  = (state != IDLE);
    assign bit_end = (cnt == divider_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            cnt <= bit_end ? divider_t'(0) : cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (valid_i) begin
                        shreg <= data_i;
                        tx_o  <= 1'b0;
                        state <= START;
                    end
                end
                START: begin
                    if (bit_end) begin
                        tx_o    <= shreg[0];
                        bit_idx <= '0;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        shreg <= shreg >> 1;
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;
                            state <= STOP;
                        end else begin
                            tx_o    <= shreg[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    // stop bit, line already high
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uart_fifo.sv
/*
 * Small synchronous FIFO used for the TX and RX byte queues.
 * Depth is 2**FIFO_PTR_WIDTH. The head is shown on rdata_o
 * without a clock delay; a push into a full FIFO or a pop from
 * an empty one is dropped.
 */

`timescale 1ns/1ns
`default_nettype none

module uart_fifo import uart_pkg::*; #(
    parameter int FIFO_PTR_WIDTH = 3
) (
    input  var logic  clk,
    input  var logic  reset,
    input  var logic  push_i,
    input  var byte_t wdata_i,
    input  var logic  pop_i,
    output var byte_t rdata_o,
    output var logic  empty_o,
    output var logic  full_o
);

    localparam int DEPTH = 1 << FIFO_PTR_WIDTH;

    byte_t mem [DEPTH];

    // extra msb tells a full FIFO from an empty one
    logic [FIFO_PTR_WIDTH:0] wr_ptr;
    logic [FIFO_PTR_WIDTH:0] rd_ptr;
    logic                    do_push;
    logic                    do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[FIFO_PTR_WIDTH] != rd_ptr[FIFO_PTR_WIDTH]) &&
                     (wr_ptr[FIFO_PTR_WIDTH-1:0] == rd_ptr[FIFO_PTR_WIDTH-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign rdata_o = mem[rd_ptr[FIFO_PTR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
/*
 * Shared types and constants for the multi-channel UART.
 * Holds the data and divider widths, the register map, the
 * per-channel control and status structs and the reset values.
 * Modules take it with a wildcard import in their header.
 */

`default_nettype none

package uart_pkg;

    // one serial data byte
    typedef logic [7:0] byte_t;

    // clk cycles per bit minus one
    typedef logic [7:0] divider_t;

    // bus data word
    typedef logic [31:0] bus_data_t;

    // register offsets inside one channel
    typedef enum logic [1:0] {
        REG_DATA    = 2'd0,
        REG_STATUS  = 2'd1,
        REG_DIVIDER = 2'd2,
        REG_NONE    = 2'd3
    } reg_adr_t;

    // --------------------------------------------------
    // per-channel control, one bus access wide
    // --------------------------------------------------
    typedef struct packed {
        logic  tx_push;
        logic  rx_pop;
        logic  div_wr;
        byte_t wdata;
    } chan_ctrl_t;

    // per-channel status, read by the mux
    typedef struct packed {
        byte_t    rx_data;
        logic     rx_valid;
        logic     tx_ready;
        logic     tx_idle;
        divider_t divider;
    } chan_stat_t;

    // 115200 baud from a 6.25 MHz clock
    localparam divider_t DIVIDER_INIT = divider_t'(53);

    // no pulse on any channel
    localparam chan_ctrl_t CHAN_CTRL_NONE = '0;

endpackage

`default_nettype wire
